/* verilog/msx_pkg.sv */
package msx_pkg;

    typedef enum logic [2:0] {
        CART_TYP_ROM      = 3'd0,
        CART_TYP_SCC      = 3'd1,
        CART_TYP_SCC_PLUS = 3'd2,
        CART_TYP_FM_PAC   = 3'd3,
        CART_TYP_GM2      = 3'd4,
        CART_TYP_FDC      = 3'd5,
        CART_TYP_EMPTY    = 3'd6
    } cart_typ_t;

    typedef enum logic [5:0] {
        MAPPER_AUTO       = 6'd0,
        MAPPER_ASCII8     = 6'd1,
        MAPPER_ASCII16    = 6'd2,
        MAPPER_KONAMI     = 6'd3,
        MAPPER_KONAMI_SCC = 6'd4,
        MAPPER_KOEI       = 6'd5,
        MAPPER_LINEAR64   = 6'd6,
        MAPPER_R_TYPE     = 6'd7,
        MAPPER_WIZARDRY   = 6'd8,
        MAPPER_NO_UNKNOWN = 6'd63
    } mapper_typ_t;

    typedef enum logic {MSX1 = 1'b0, MSX2 = 1'b1} msx_typ_t;

    typedef enum logic [1:0] {
        VIDEO_AUTO     = 2'd0,
        VIDEO_PAL      = 2'd1,
        VIDEO_NTSC     = 2'd2,
        VIDEO_RESERVED = 2'd3
    } video_mode_t;

    typedef enum logic {CAS_AUDIO_FILE = 1'b0, CAS_AUDIO_ADC = 1'b1} cas_audio_src_t;

    typedef enum logic [1:0] {SIZE128 = 2'd0, SIZE64 = 2'd1, SIZE512 = 2'd2, SIZE256 = 2'd3} ram_size_t;

    // sram_size is a log2 code, 0 is none and 4 is 8 kB.
    typedef struct packed {
        cart_typ_t   typ;
        mapper_typ_t mapper;
        logic [2:0]  sram_size;
    } config_cart_t;

    typedef struct packed {
        msx_typ_t       typ;
        logic           scandoubler;
        video_mode_t    video_mode;
        cas_audio_src_t cas_audio_src;
        ram_size_t      ram_size;
        logic           border;
    } config_t;

endpackage

/* verilog/host_pkg.sv */
package host_pkg;

    // status word fields.
    localparam int SLOT_A_LSB   = 17;
    localparam int SLOT_B_LSB   = 29;
    localparam int SRAM_A_LSB   = 26;
    localparam int MAPPER_A_LSB = 20;
    localparam int MAPPER_B_LSB = 32;
    localparam int RAM_SIZE_LSB = 15;
    localparam int VIDEO_LSB    = 12;
    localparam int CAS_SRC_BIT  = 8;
    localparam int EJECT_BIT    = 10;
    localparam int BORDER_BIT   = 38;
    localparam int SLOT_W       = 3;
    localparam int MAPPER_W     = 4;
    localparam int SRAM_W       = 3;

    // wishbone word addresses.
    localparam logic [1:0] REG_STATUS_LO = 2'd0;
    localparam logic [1:0] REG_STATUS_HI = 2'd1;
    localparam logic [1:0] REG_SUMMARY   = 2'd2;

    // summary word layout.
    localparam int SUM_SLOT_A_LSB    = 0;
    localparam int SUM_SLOT_B_LSB    = 3;
    localparam int SUM_SRAM_A_LSB    = 6;
    localparam int SUM_FDC_BIT       = 9;
    localparam int SUM_HIDE_LSB      = 10;
    localparam int SUM_RESET_REQ_BIT = 14;
    localparam int SUM_MACHINE_LSB   = 15;

endpackage

/* verilog/msx_cfg_if.sv */
`timescale 1ns/1ps

interface msx_cfg_if import msx_pkg::*; ();

    config_cart_t cart_conf [2];
    config_t      machine_conf;
    logic         sram_a_select_hide;
    logic         sram_loadsave_hide;
    logic         rom_a_load_hide;
    logic         rom_b_load_hide;
    logic         fdc_enabled;
    logic         reset_request;

    modport decoder (
        output cart_conf, machine_conf,
        output sram_a_select_hide, sram_loadsave_hide,
        output rom_a_load_hide, rom_b_load_hide,
        output fdc_enabled, reset_request
    );

    modport host (
        input cart_conf, machine_conf,
        input sram_a_select_hide, sram_loadsave_hide,
        input rom_a_load_hide, rom_b_load_hide,
        input fdc_enabled, reset_request
    );

endinterface

/* verilog/host_status_regs.sv */
`timescale 1ns/1ps

module host_status_regs import host_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack,
    output logic [63:0] status,
    msx_cfg_if.host     cfg
);

    logic [31:0] status_lo;
    logic [31:0] status_hi;
    logic [31:0] summary;
    logic        req;

    // a new cycle is taken only while ack is low, so ack lasts one cycle.
    assign req = wb_cyc && wb_stb && !wb_ack;

    assign status = {status_hi, status_lo};

    always_comb begin
        summary = '0;
        summary[SUM_SLOT_A_LSB +: 3] = cfg.cart_conf[0].typ;
        summary[SUM_SLOT_B_LSB +: 3] = cfg.cart_conf[1].typ;
        summary[SUM_SRAM_A_LSB +: 3] = cfg.cart_conf[0].sram_size;
        summary[SUM_FDC_BIT] = cfg.fdc_enabled;
        summary[SUM_HIDE_LSB] = cfg.sram_a_select_hide;
        summary[SUM_HIDE_LSB + 1] = cfg.sram_loadsave_hide;
        summary[SUM_HIDE_LSB + 2] = cfg.rom_a_load_hide;
        summary[SUM_HIDE_LSB + 3] = cfg.rom_b_load_hide;
        summary[SUM_RESET_REQ_BIT] = cfg.reset_request;
        summary[SUM_MACHINE_LSB +: 8] = cfg.machine_conf;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_ack    <= 1'b0;
            status_lo <= '0;
            status_hi <= '0;
        end else begin
            wb_ack <= req;
            if (req && wb_we) begin
                case (wb_adr)
                    REG_STATUS_LO: begin
                        status_lo <= wb_dat_w;
                    end
                    REG_STATUS_HI: begin
                        status_hi <= wb_dat_w;
                    end
                    // summary and address 3 are read only.
                    default: begin
                    end
                endcase
            end
        end
    end

    // read data is captured with the request and held while ack is high.
    always_ff @(posedge clk) begin
        if (req) begin
            case (wb_adr)
                REG_STATUS_LO: begin
                    wb_dat_r <= status_lo;
                end
                REG_STATUS_HI: begin
                    wb_dat_r <= status_hi;
                end
                REG_SUMMARY: begin
                    wb_dat_r <= summary;
                end
                default: begin
                    wb_dat_r <= '0;
                end
            endcase
        end
    end

endmodule

/* verilog/msx_config.sv */
`timescale 1ns/1ps

module msx_config import msx_pkg::*, host_pkg::*; (
    input  logic        clk,
    input  logic        core_reset,
    input  logic        msx_type,
    input  logic        scandoubler,
    input  logic [63:0] status,
    input  logic [5:0]  mapper_detected [2],
    input  logic [2:0]  sram_size_detected [2],
    input  logic [1:0]  sdram_size,
    msx_cfg_if.decoder  cfg,
    output logic [1:0]  cart_changed,
    output logic [1:0]  rom_eject
);

    logic [SLOT_W-1:0]   slot_a_sel;
    logic [SLOT_W-1:0]   slot_b_sel;
    logic [MAPPER_W-1:0] mapper_a_sel;
    logic [MAPPER_W-1:0] mapper_b_sel;
    logic [SRAM_W-1:0]   sram_a_sel;
    msx_typ_t            machine_typ;
    cart_typ_t           slot_a_typ;
    cart_typ_t           slot_b_typ;
    logic [2:0]          sram_a_size;
    logic [2:0]          sram_b_size;
    ram_size_t           ram_size;
    logic [18:0]         act_config;
    logic [18:0]         ref_config;
    logic [5:0]          act_cart_typ;
    logic [5:0]          last_cart_typ;

    function automatic mapper_typ_t decode_mapper(input logic [MAPPER_W-1:0] sel,
                                                  input logic [5:0] detected);
        // selections from 9 up mean no mapper.
        if (sel >= MAPPER_W'(9))
            return MAPPER_NO_UNKNOWN;
        else if (sel == '0)
            return mapper_typ_t'(detected);
        else
            return mapper_typ_t'({2'b00, sel});
    endfunction

    assign slot_a_sel   = status[SLOT_A_LSB +: SLOT_W];
    assign slot_b_sel   = status[SLOT_B_LSB +: SLOT_W];
    assign mapper_a_sel = status[MAPPER_A_LSB +: MAPPER_W];
    assign mapper_b_sel = status[MAPPER_B_LSB +: MAPPER_W];
    assign sram_a_sel   = status[SRAM_A_LSB +: SRAM_W];
    assign machine_typ  = msx_typ_t'(msx_type);

    always_comb begin
        if (slot_a_sel < 3'd5)
            slot_a_typ = cart_typ_t'(slot_a_sel);
        else if (slot_a_sel == 3'd5 && machine_typ == MSX1)
            slot_a_typ = CART_TYP_FDC;
        else
            slot_a_typ = CART_TYP_EMPTY;
    end

    assign slot_b_typ = slot_b_sel < 3'd4 ? cart_typ_t'(slot_b_sel) : CART_TYP_EMPTY;

    // sram selection is offered only for a ROM with a fixed mapper.
    assign cfg.sram_a_select_hide = slot_a_typ != CART_TYP_ROM || mapper_a_sel == '0;

    always_comb begin
        if (slot_a_typ == CART_TYP_FM_PAC || slot_a_typ == CART_TYP_GM2)
            sram_a_size = 3'd4;
        else if (sram_a_sel == 3'd7)
            sram_a_size = 3'd0;
        else if (cfg.sram_a_select_hide || sram_a_sel == 3'd0)
            sram_a_size = sram_size_detected[0];
        else if (sdram_size == 2'd0 && sram_a_sel > 3'd4)
            sram_a_size = 3'd4;
        else
            sram_a_size = sram_a_sel;
    end

    assign sram_b_size = slot_b_typ == CART_TYP_FM_PAC ? 3'd4 : 3'd0;

    assign cfg.cart_conf[0] = '{typ: slot_a_typ,
                                mapper: decode_mapper(mapper_a_sel, mapper_detected[0]),
                                sram_size: sram_a_size};
    assign cfg.cart_conf[1] = '{typ: slot_b_typ,
                                mapper: decode_mapper(mapper_b_sel, mapper_detected[1]),
                                sram_size: sram_b_size};

    // small sdram only holds 64 kB of RAM.
    assign ram_size = sdram_size == 2'd0 ? SIZE64 : ram_size_t'(status[RAM_SIZE_LSB +: 2]);

    assign cfg.machine_conf.typ           = machine_typ;
    assign cfg.machine_conf.scandoubler   = scandoubler;
    assign cfg.machine_conf.video_mode    = machine_typ == MSX1 ?
        (status[VIDEO_LSB] ? VIDEO_NTSC : VIDEO_PAL) : video_mode_t'(status[VIDEO_LSB + 1 +: 2]);
    assign cfg.machine_conf.cas_audio_src = cas_audio_src_t'(status[CAS_SRC_BIT]);
    assign cfg.machine_conf.ram_size      = ram_size;
    assign cfg.machine_conf.border        = status[BORDER_BIT];

    assign cfg.sram_loadsave_hide = sram_a_size == 3'd0 && sram_b_size == 3'd0;
    assign cfg.rom_a_load_hide    = slot_a_typ != CART_TYP_ROM;
    assign cfg.rom_b_load_hide    = slot_b_typ != CART_TYP_ROM;
    assign cfg.fdc_enabled        = machine_typ == MSX2 || slot_a_typ == CART_TYP_FDC;

    assign act_config   = {slot_b_typ, slot_a_typ, mapper_a_sel, mapper_b_sel, sram_a_sel, ram_size};
    assign act_cart_typ = {slot_b_typ, slot_a_typ};

    // the reference follows the live fields for as long as the core is held in reset.
    always_ff @(posedge clk) begin
        if (core_reset)
            ref_config <= act_config;
        last_cart_typ <= act_cart_typ;
    end

    assign cfg.reset_request = ref_config != act_config;

    assign cart_changed[0] = last_cart_typ[2:0] != act_cart_typ[2:0];
    assign cart_changed[1] = last_cart_typ[5:3] != act_cart_typ[5:3];

    assign rom_eject[0] = slot_a_typ == CART_TYP_ROM && status[EJECT_BIT];
    assign rom_eject[1] = slot_b_typ == CART_TYP_ROM && status[EJECT_BIT];

endmodule

/* verilog/reset_sequencer.sv */
`timescale 1ns/1ps

module reset_sequencer #(
    parameter int RESET_CYCLES = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic reset_request,
    output logic core_reset
);

    localparam int CNT_W = RESET_CYCLES > 1 ? $clog2(RESET_CYCLES) : 1;
    localparam logic [CNT_W-1:0] LOAD = CNT_W'(RESET_CYCLES - 1);

    // cycles left in the pulse after the current one.
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            core_reset <= 1'b1;
            count      <= LOAD;
        end else if (core_reset) begin
            // a request during the pulse is not remembered.
            if (count == '0)
                core_reset <= 1'b0;
            else
                count <= count - 1'b1;
        end else if (reset_request) begin
            core_reset <= 1'b1;
            count      <= LOAD;
        end
    end

endmodule

/* verilog/msx_config_top.sv */
`timescale 1ns/1ps

module msx_config_top import msx_pkg::*; #(
    parameter int RESET_CYCLES = 4
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         wb_cyc,
    input  logic         wb_stb,
    input  logic         wb_we,
    input  logic [1:0]   wb_adr,
    input  logic [31:0]  wb_dat_w,
    output logic [31:0]  wb_dat_r,
    output logic         wb_ack,
    input  logic         msx_type,
    input  logic         scandoubler,
    input  logic [5:0]   mapper_detected [2],
    input  logic [2:0]   sram_size_detected [2],
    input  logic [1:0]   sdram_size,
    output config_cart_t cart_conf [2],
    output config_t      machine_conf,
    output logic         fdc_enabled,
    output logic         sram_a_select_hide,
    output logic         sram_loadsave_hide,
    output logic         rom_a_load_hide,
    output logic         rom_b_load_hide,
    output logic         core_reset,
    output logic [1:0]   cart_changed,
    output logic [1:0]   rom_eject
);

    logic [63:0] status;

    msx_cfg_if cfg_bus ();

    host_status_regs u_regs (
        .clk      (clk),
        .reset    (reset),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .status   (status),
        .cfg      (cfg_bus.host)
    );

    msx_config u_config (
        .clk                (clk),
        .core_reset         (core_reset),
        .msx_type           (msx_type),
        .scandoubler        (scandoubler),
        .status             (status),
        .mapper_detected    (mapper_detected),
        .sram_size_detected (sram_size_detected),
        .sdram_size         (sdram_size),
        .cfg                (cfg_bus.decoder),
        .cart_changed       (cart_changed),
        .rom_eject          (rom_eject)
    );

    reset_sequencer #(
        .RESET_CYCLES (RESET_CYCLES)
    ) u_reset_seq (
        .clk           (clk),
        .reset         (reset),
        .reset_request (cfg_bus.reset_request),
        .core_reset    (core_reset)
    );

    assign cart_conf          = cfg_bus.cart_conf;
    assign machine_conf       = cfg_bus.machine_conf;
    assign fdc_enabled        = cfg_bus.fdc_enabled;
    assign sram_a_select_hide = cfg_bus.sram_a_select_hide;
    assign sram_loadsave_hide = cfg_bus.sram_loadsave_hide;
    assign rom_a_load_hide    = cfg_bus.rom_a_load_hide;
    assign rom_b_load_hide    = cfg_bus.rom_b_load_hide;

endmodule

/* bench/msx_config_props.sv */
`timescale 1ns/1ps

module msx_config_props #(
    parameter int RESET_CYCLES = 4
) (
    input logic clk,
    input logic reset,
    input logic wb_cyc,
    input logic wb_stb,
    input logic wb_ack,
    input logic core_reset
);

    int failures = 0;

    // ack is a single-cycle strobe.
    ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_ack |=> !wb_ack)
        else begin
            failures++;
            $error("wishbone ack held high for two cycles");
        end

    ack_after_request: assert property (@(posedge clk) disable iff (reset)
        wb_ack |-> $past(wb_cyc && wb_stb))
        else begin
            failures++;
            $error("wishbone ack without a request in the previous cycle");
        end

    // the power-up pulse starts inside reset and is not covered here.
    core_reset_length: assert property (@(posedge clk) disable iff (reset)
        $rose(core_reset) |-> core_reset [*RESET_CYCLES] ##1 !core_reset)
        else begin
            failures++;
            $error("core reset pulse length differs from %0d cycles", RESET_CYCLES);
        end

endmodule

bind msx_config_top msx_config_props #(.RESET_CYCLES(RESET_CYCLES)) u_props (
    .clk        (clk),
    .reset      (reset),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_ack     (wb_ack),
    .core_reset (core_reset)
);

/* bench/tb_msx_config.sv */
`timescale 1ns/1ps

module tb_msx_config import msx_pkg::*, host_pkg::*; ();

    localparam int WB_TIMEOUT = 20;
    localparam int RST_TIMEOUT = 100;

    logic         clk;
    logic         reset;
    logic         wb_cyc;
    logic         wb_stb;
    logic         wb_we;
    logic [1:0]   wb_adr;
    logic [31:0]  wb_dat_w;
    logic [31:0]  wb_dat_r;
    logic         wb_ack;
    logic         msx_type;
    logic         scandoubler;
    logic [5:0]   mapper_detected [2];
    logic [2:0]   sram_size_detected [2];
    logic [1:0]   sdram_size;
    config_cart_t cart_conf [2];
    config_t      machine_conf;
    logic         fdc_enabled;
    logic         sram_a_select_hide;
    logic         sram_loadsave_hide;
    logic         rom_a_load_hide;
    logic         rom_b_load_hide;
    logic         core_reset;
    logic [1:0]   cart_changed;
    logic [1:0]   rom_eject;

    msx_config_top #(.RESET_CYCLES(4)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic halt_run();
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(string name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
            halt_run();
        end
    endtask

    // every task starts and ends 1 ns after a rising edge.
    task automatic step(int n = 1);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] data,
                             output logic [31:0] rdata);
        int cycles;
        cycles = 0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = data;
        do begin
            step();
            cycles++;
            if (cycles > WB_TIMEOUT) begin
                $display("no wishbone ack within %0d cycles at address %0d", WB_TIMEOUT, adr);
                halt_run();
            end
        end while (!wb_ack);
        rdata = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_write(logic [1:0] adr, logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [1:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, '0, data);
    endtask

    task automatic write_status(logic [63:0] s);
        wb_write(REG_STATUS_LO, s[31:0]);
        wb_write(REG_STATUS_HI, s[63:32]);
    endtask

    // three quiet cycles in a row means no request is pending.
    task automatic settle();
        int cycles;
        int quiet;
        cycles = 0;
        quiet = 0;
        while (quiet < 3) begin
            step();
            quiet = core_reset ? 0 : quiet + 1;
            cycles++;
            if (cycles > RST_TIMEOUT) begin
                $display("core reset did not settle within %0d cycles", RST_TIMEOUT);
                halt_run();
            end
        end
    endtask

    // cycles that core_reset stays high, counted from the current one.
    task automatic measure_reset_pulse(output int high);
        high = 0;
        while (core_reset) begin
            high++;
            step();
            if (high > RST_TIMEOUT) begin
                $display("core reset stuck high for more than %0d cycles", RST_TIMEOUT);
                halt_run();
            end
        end
    endtask

    function automatic logic [2:0] slot_a_expect(logic [2:0] sel, logic msx2);
        case (sel)
            3'd5: return msx2 ? 3'd6 : 3'd5;
            3'd6, 3'd7: return 3'd6;
            default: return sel;
        endcase
    endfunction

    function automatic logic [2:0] slot_b_expect(logic [2:0] sel);
        return sel > 3'd3 ? 3'd6 : sel;
    endfunction

    function automatic logic [5:0] mapper_expect(logic [3:0] sel, logic [5:0] detected);
        if (sel == 4'd0)
            return detected;
        return sel == 4'd9 ? 6'd63 : {2'b00, sel};
    endfunction

    function automatic logic [2:0] sram_a_expect(logic [63:0] s, logic msx2, logic [2:0] detected,
                                                 logic [1:0] sdram);
        logic [2:0] typ;
        logic [2:0] sel;
        typ = slot_a_expect(s[SLOT_A_LSB +: 3], msx2);
        sel = s[SRAM_A_LSB +: 3];
        if (typ == 3'd3 || typ == 3'd4)
            return 3'd4;
        if (sel == 3'd7)
            return 3'd0;
        if (typ != 3'd0 || s[MAPPER_A_LSB +: 4] == 4'd0 || sel == 3'd0)
            return detected;
        if (sdram == 2'd0 && sel > 3'd4)
            return 3'd4;
        return sel;
    endfunction

    function automatic logic [7:0] machine_expect(logic [63:0] s, logic msx2, logic sd,
                                                  logic [1:0] sdram);
        logic [1:0] video;
        logic [1:0] ram;
        video = msx2 ? s[VIDEO_LSB + 1 +: 2] : (s[VIDEO_LSB] ? 2'd2 : 2'd1);
        ram = sdram == 2'd0 ? 2'd1 : s[RAM_SIZE_LSB +: 2];
        return {msx2, sd, video, s[CAS_SRC_BIT], ram, s[BORDER_BIT]};
    endfunction

    task automatic test_power_up();
        logic [31:0] data;
        int          high;
        measure_reset_pulse(high);
        check("power_up core_reset length", 4, high);
        check("power_up cart_changed", 0, cart_changed);
        check("power_up rom_eject", 0, rom_eject);
        check("power_up slot_a", CART_TYP_ROM, cart_conf[0].typ);
        check("power_up slot_b", CART_TYP_ROM, cart_conf[1].typ);
        wb_read(REG_STATUS_LO, data);
        check("power_up status_lo", 0, data);
        wb_read(REG_SUMMARY, data);
        check("power_up reset_request", 0, data[SUM_RESET_REQ_BIT]);
    endtask

    task automatic test_cart_types();
        logic [63:0] s;
        logic [31:0] data;
        logic [2:0]  exp_a;
        for (int m = 0; m < 2; m++) begin
            for (int sel = 0; sel < 8; sel++) begin
                msx_type = m[0];
                s = '0;
                s[SLOT_A_LSB +: 3] = sel[2:0];
                s[SLOT_B_LSB +: 3] = sel[2:0];
                wb_write(REG_STATUS_LO, s[31:0]);
                exp_a = slot_a_expect(sel[2:0], m[0]);
                check("cart_types slot_a", exp_a, cart_conf[0].typ);
                check("cart_types slot_b", slot_b_expect(sel[2:0]), cart_conf[1].typ);
                check("cart_types fdc_enabled", m[0] || exp_a == 3'd5, fdc_enabled);
                check("cart_types rom_a_hide", exp_a != 3'd0, rom_a_load_hide);
                check("cart_types rom_b_hide", slot_b_expect(sel[2:0]) != 3'd0, rom_b_load_hide);
                wb_read(REG_SUMMARY, data);
                check("cart_types summary slot_b", slot_b_expect(sel[2:0]),
                      data[SUM_SLOT_B_LSB +: 3]);
                check("cart_types summary fdc", m[0] || exp_a == 3'd5, data[SUM_FDC_BIT]);
            end
        end
    endtask

    task automatic test_mappers();
        logic [63:0] s;
        logic [3:0]  sel_a;
        logic [3:0]  sel_b;
        for (int i = 0; i < 12; i++) begin
            sel_a = i == 0 ? 4'd9 : (i == 1 ? 4'd0 : 4'($urandom_range(9)));
            sel_b = i == 0 ? 4'd0 : (i == 1 ? 4'd9 : 4'($urandom_range(9)));
            mapper_detected[0] = 6'($urandom);
            mapper_detected[1] = 6'($urandom);
            s = '0;
            s[MAPPER_A_LSB +: 4] = sel_a;
            s[MAPPER_B_LSB +: 4] = sel_b;
            write_status(s);
            check("mappers slot_a", mapper_expect(sel_a, mapper_detected[0]), cart_conf[0].mapper);
            check("mappers slot_b", mapper_expect(sel_b, mapper_detected[1]), cart_conf[1].mapper);
        end
    endtask

    task automatic test_sram();
        // one column per case: slot a, mapper a, sram a, slot b, sdram size.
        int          slot_a [8]   = '{3, 4, 0, 0, 0, 0, 0, 1};
        int          mapper_a [8] = '{1, 1, 1, 0, 1, 2, 2, 1};
        int          sram_a [8]   = '{7, 0, 7, 2, 0, 6, 6, 3};
        int          slot_b [8]   = '{3, 0, 0, 0, 1, 0, 0, 3};
        int          sdram [8]    = '{1, 1, 1, 1, 1, 0, 2, 3};
        logic [63:0] s;
        logic [31:0] data;
        logic [2:0]  exp_a;
        logic [2:0]  exp_b;
        logic [3:0]  exp_hide;
        msx_type = 1'b0;
        for (int i = 0; i < 8; i++) begin
            sram_size_detected[0] = 3'($urandom);
            sdram_size = 2'(sdram[i]);
            s = '0;
            s[SLOT_A_LSB +: 3]   = 3'(slot_a[i]);
            s[MAPPER_A_LSB +: 4] = 4'(mapper_a[i]);
            s[SRAM_A_LSB +: 3]   = 3'(sram_a[i]);
            s[SLOT_B_LSB +: 3]   = 3'(slot_b[i]);
            wb_write(REG_STATUS_LO, s[31:0]);
            exp_a = sram_a_expect(s, 1'b0, sram_size_detected[0], sdram_size);
            exp_b = slot_b_expect(s[SLOT_B_LSB +: 3]) == 3'd3 ? 3'd4 : 3'd0;
            // rom b, rom a, load/save and sram select, from the top bit down.
            exp_hide = {slot_b_expect(s[SLOT_B_LSB +: 3]) != 3'd0, slot_a[i] != 0,
                        exp_a == 3'd0 && exp_b == 3'd0, slot_a[i] != 0 || mapper_a[i] == 0};
            check("sram slot_a", exp_a, cart_conf[0].sram_size);
            check("sram slot_b", exp_b, cart_conf[1].sram_size);
            check("sram select_hide", slot_a[i] != 0 || mapper_a[i] == 0, sram_a_select_hide);
            check("sram loadsave_hide", exp_a == 3'd0 && exp_b == 3'd0, sram_loadsave_hide);
            wb_read(REG_SUMMARY, data);
            check("sram summary", exp_a, data[SUM_SRAM_A_LSB +: 3]);
            check("sram summary hide", exp_hide, data[SUM_HIDE_LSB +: 4]);
        end
    endtask

    task automatic test_cart_change();
        logic [31:0] s;
        logic [31:0] data;
        int          high;
        s = '0;
        s[EJECT_BIT] = 1'b1;
        wb_write(REG_STATUS_LO, s);
        check("cart_change eject both rom", 2'b11, rom_eject);
        settle();
        s[SLOT_B_LSB +: 3] = 3'd1;
        wb_write(REG_STATUS_LO, s);
        check("cart_change pulse", 2'b10, cart_changed);
        check("cart_change eject slot_a only", 2'b01, rom_eject);
        step();
        check("cart_change pulse end", 2'b00, cart_changed);
        measure_reset_pulse(high);
        check("cart_change core_reset length", 4, high);
        wb_read(REG_SUMMARY, data);
        check("cart_change reset_request", 0, data[SUM_RESET_REQ_BIT]);
        s[SLOT_A_LSB +: 3] = 3'd6;
        s[SLOT_B_LSB +: 3] = 3'd0;
        wb_write(REG_STATUS_LO, s);
        check("cart_change pulse both slots", 2'b11, cart_changed);
        check("cart_change eject slot_b only", 2'b10, rom_eject);
        settle();
    endtask

    task automatic test_machine();
        logic [63:0] s;
        logic [31:0] data;
        logic [7:0]  exp_m;
        for (int i = 0; i < 8; i++) begin
            s = {$urandom, $urandom};
            msx_type = i[0];
            scandoubler = 1'($urandom_range(1));
            sdram_size = i < 2 ? 2'd0 : 2'($urandom);
            write_status(s);
            exp_m = machine_expect(s, i[0], scandoubler, sdram_size);
            check("machine machine_conf", exp_m, machine_conf);
            wb_read(REG_SUMMARY, data);
            check("machine summary", exp_m, data[SUM_MACHINE_LSB +: 8]);
            check("machine summary slot_a", slot_a_expect(s[SLOT_A_LSB +: 3], i[0]), data[2:0]);
        end
    endtask

    initial begin
        int unsigned seed_draw;
        seed_draw = $urandom(63);
        reset = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        msx_type = 1'b0;
        scandoubler = 1'b0;
        mapper_detected[0] = '0;
        mapper_detected[1] = '0;
        sram_size_detected[0] = '0;
        sram_size_detected[1] = '0;
        sdram_size = 2'd1;
        step(3);
        reset = 1'b0;
        test_power_up();
        test_cart_types();
        test_mappers();
        test_sram();
        test_cart_change();
        test_machine();
        settle();
        if (DUT.u_props.failures != 0) begin
            $display("%0d assertion failures in the bound checker", DUT.u_props.failures);
            halt_run();
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

/* src.f */
verilog/msx_pkg.sv
verilog/host_pkg.sv
verilog/msx_cfg_if.sv
verilog/host_status_regs.sv
verilog/msx_config.sv
verilog/reset_sequencer.sv
verilog/msx_config_top.sv
bench/msx_config_props.sv
bench/tb_msx_config.sv

/* Bender.yml */
package:
  name: msx_config

sources:
  - files:
      - verilog/msx_pkg.sv
      - verilog/host_pkg.sv
      - verilog/msx_cfg_if.sv
      - verilog/host_status_regs.sv
      - verilog/msx_config.sv
      - verilog/reset_sequencer.sv
      - verilog/msx_config_top.sv
  - target: simulation
    files:
      - bench/msx_config_props.sv
      - bench/tb_msx_config.sv
